// File: logic/audio_mixer.sv
`timescale 1ns/100ps

module audio_mixer (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  audio_pkg::sample_t     fm_comp_i,
	input  audio_pkg::sid_sample_t sid_left_i,
	input  audio_pkg::sid_sample_t sid_right_i,
	input  audio_pkg::dac_sum_t    dac_l_i,
	input  audio_pkg::dac_sum_t    dac_r_i,
	input  logic                   tape_sound_i,
	output audio_pkg::sample_t     audio_l_o,
	output audio_pkg::sample_t     audio_r_o
);

	import audio_pkg::*;

	// DAC sums are scaled by 64, tape adds a fixed 1024
	localparam int DAC_SHIFT = 6;
	localparam int DAC_PAD   = SAMPLE_W - DAC_W - DAC_SHIFT;
	localparam logic [SAMPLE_W:0] TAPE_LEVEL = (SAMPLE_W+1)'(1024);

	logic [SAMPLE_W:0] sum_l;
	logic [SAMPLE_W:0] sum_r;

	// ============================================================
	// Per-channel sum in one guard bit
	// ============================================================
	function automatic logic [SAMPLE_W:0] mix_sum(
		input sample_t     fm,
		input sid_sample_t sid,
		input dac_sum_t    dac,
		input logic        tape
	);
		logic [SAMPLE_W:0] fm_term;
		logic [SAMPLE_W:0] sid_term;
		logic [SAMPLE_W:0] dac_term;
		logic [SAMPLE_W:0] tape_term;

		fm_term   = {fm[SAMPLE_W-1], fm};
		// Quarter of the SID sample, sign kept
		sid_term  = {sid[SID_W-1], sid[SID_W-1:2]};
		dac_term  = {{DAC_PAD{1'b0}}, dac, {DAC_SHIFT{1'b0}}};
		tape_term = tape ? TAPE_LEVEL : '0;
		return fm_term + sid_term + dac_term + tape_term;
	endfunction

	// Clamp when the guard bit and the sign disagree
	function automatic sample_t saturate(input logic [SAMPLE_W:0] s);
		if (s[SAMPLE_W] ^ s[SAMPLE_W-1])
			return {s[SAMPLE_W], {(SAMPLE_W-1){s[SAMPLE_W-1]}}};
		return s[SAMPLE_W-1:0];
	endfunction

	// ============================================================
	// Sum stage, then saturation stage
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			sum_l     <= '0;
			sum_r     <= '0;
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			sum_l     <= mix_sum(fm_comp_i, sid_left_i, dac_l_i, tape_sound_i);
			sum_r     <= mix_sum(fm_comp_i, sid_right_i, dac_r_i, tape_sound_i);
			audio_l_o <= saturate(sum_l);
			audio_r_o <= saturate(sum_r);
		end
	end

endmodule

// File: logic/audio_pkg.sv
package audio_pkg;

	// ============================================================
	// Sample and register widths
	// ============================================================
	localparam int SAMPLE_W = 16;
	localparam int SID_W    = 18;
	localparam int DAC_W    = 8;
	localparam int DAC_CH   = 4;

	// ============================================================
	// Sample types
	// ============================================================
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [SID_W-1:0]    sid_sample_t;

	// DigiMax register and the sum of two registers
	typedef logic [DAC_W-1:0] dac_byte_t;
	typedef logic [DAC_W:0]   dac_sum_t;

	// Where the DigiMax cartridge answers, value 3 maps to the second window
	typedef enum logic [1:0] {
		DIGIMAX_OFF = 2'd0,
		DIGIMAX_IO1 = 2'd1,
		DIGIMAX_IO2 = 2'd2
	} digimax_port_t;

endpackage

// File: logic/audio_top.sv
`timescale 1ns/100ps

module audio_top #(
	parameter int COMP_RATIO = 4,
	parameter int COMP_GAIN  = 2
) (
	input  logic                     clk_sys,
	input  logic                     reset_n,
	input  logic                     io_e_i,
	input  logic                     io_f_i,
	input  logic                     cpu_we_i,
	input  logic [2:0]               cpu_addr_i,
	input  audio_pkg::dac_byte_t     cpu_data_i,
	input  audio_pkg::digimax_port_t digimax_port_i,
	input  audio_pkg::sample_t       fm_sample_i,
	input  audio_pkg::sid_sample_t   sid_left_i,
	input  audio_pkg::sid_sample_t   sid_right_i,
	input  logic                     tape_sound_i,
	output audio_pkg::sample_t       audio_l_o,
	output audio_pkg::sample_t       audio_r_o
);

	import audio_pkg::*;

	dac_sum_t dac_l;
	dac_sum_t dac_r;
	sample_t  fm_comp;

	// DigiMax register decode
	digimax_regs i_digimax_regs (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.io_e_i         (io_e_i),
		.io_f_i         (io_f_i),
		.cpu_we_i       (cpu_we_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_data_i     (cpu_data_i),
		.digimax_port_i (digimax_port_i),
		.dac_l_o        (dac_l),
		.dac_r_o        (dac_r)
	);

	// FM sample compression
	fm_compressor #(
		.COMP_RATIO (COMP_RATIO),
		.COMP_GAIN  (COMP_GAIN)
	) i_fm_compressor (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.fm_sample_i (fm_sample_i),
		.fm_comp_o   (fm_comp)
	);

	// Final stereo mix
	audio_mixer i_audio_mixer (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.fm_comp_i    (fm_comp),
		.sid_left_i   (sid_left_i),
		.sid_right_i  (sid_right_i),
		.dac_l_i      (dac_l),
		.dac_r_i      (dac_r),
		.tape_sound_i (tape_sound_i),
		.audio_l_o    (audio_l_o),
		.audio_r_o    (audio_r_o)
	);

endmodule

// File: logic/digimax_regs.sv
`timescale 1ns/100ps

module digimax_regs (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      io_e_i,
	input  logic                      io_f_i,
	input  logic                      cpu_we_i,
	input  logic [2:0]                cpu_addr_i,
	input  audio_pkg::dac_byte_t      cpu_data_i,
	input  audio_pkg::digimax_port_t  digimax_port_i,
	output audio_pkg::dac_sum_t       dac_l_o,
	output audio_pkg::dac_sum_t       dac_r_o
);

	import audio_pkg::*;

	logic      old_ioe;
	logic      old_iof;
	logic      ioe_we;
	logic      iof_we;
	logic      win_we;
	dac_byte_t dac_reg [DAC_CH];
	logic [DAC_CH-1:0] act;

	function automatic dac_sum_t add_dac(input dac_byte_t a, input dac_byte_t b);
		return {1'b0, a} + {1'b0, b};
	endfunction

	// ============================================================
	// Write strobes on the rising edge of each I/O window
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			old_ioe <= 1'b0;
			old_iof <= 1'b0;
			ioe_we  <= 1'b0;
			iof_we  <= 1'b0;
		end else begin
			old_ioe <= io_e_i;
			old_iof <= io_f_i;
			ioe_we  <= ~old_ioe & io_e_i & cpu_we_i;
			iof_we  <= ~old_iof & io_f_i & cpu_we_i;
		end
	end

	// Pick the strobe of the selected window
	always_comb begin
		case (digimax_port_i)
			DIGIMAX_OFF: win_we = 1'b0;
			DIGIMAX_IO1: win_we = ioe_we;
			DIGIMAX_IO2: win_we = iof_we;
			default:     win_we = iof_we;
		endcase
	end

	// ============================================================
	// DAC registers and activity bits
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n || digimax_port_i == DIGIMAX_OFF) begin
			for (int i = 0; i < DAC_CH; i++) begin
				dac_reg[i] <= '0;
			end
			act <= '0;
		end else if (win_we && !cpu_addr_i[2]) begin
			dac_reg[cpu_addr_i[1:0]] <= cpu_data_i;
			// A channel counts as used once it sees a non-zero byte
			if (cpu_data_i != '0)
				act[cpu_addr_i[1:0]] <= 1'b1;
		end
	end

	// Guess mono, stereo or four-channel from the used channels
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			dac_l_o <= '0;
			dac_r_o <= '0;
		end else if (act < 4'd2) begin
			dac_l_o <= add_dac(dac_reg[0], dac_reg[0]);
			dac_r_o <= add_dac(dac_reg[0], dac_reg[0]);
		end else if (act < 4'd3) begin
			dac_l_o <= add_dac(dac_reg[1], dac_reg[1]);
			dac_r_o <= add_dac(dac_reg[0], dac_reg[0]);
		end else begin
			dac_l_o <= add_dac(dac_reg[1], dac_reg[2]);
			dac_r_o <= add_dac(dac_reg[0], dac_reg[3]);
		end
	end

endmodule

// File: logic/fm_compressor.sv
`timescale 1ns/100ps

module fm_compressor #(
	parameter int COMP_RATIO = 4,
	parameter int COMP_GAIN  = 2
) (
	input  logic               clk_sys,
	input  logic               reset_n,
	input  audio_pkg::sample_t fm_sample_i,
	output audio_pkg::sample_t fm_comp_o
);

	import audio_pkg::*;

	// ============================================================
	// Curve constants
	// ============================================================
	localparam int MAX_POS = 2**(SAMPLE_W-1) - 1;
	// One above the exact knee so the upper slope never overflows
	localparam int KNEE    = (MAX_POS * (COMP_RATIO - 1)) / (COMP_RATIO * COMP_GAIN - 1) + 1;
	localparam int OFFSET  = KNEE * COMP_GAIN;

	localparam logic [SAMPLE_W-1:0] KNEE_U   = SAMPLE_W'(KNEE);
	localparam logic [SAMPLE_W-1:0] OFFSET_U = SAMPLE_W'(OFFSET);

	sample_t             atten_r;
	logic [SAMPLE_W-1:0] mag;
	logic [SAMPLE_W-1:0] curve;
	sample_t             comp_next;

	// Stage one, attenuate to seven eighths
	always_ff @(posedge clk_sys) begin
		if (!reset_n)
			atten_r <= '0;
		else
			atten_r <= fm_sample_i - (fm_sample_i >>> 3);
	end

	// ============================================================
	// Two-slope curve on the magnitude
	// ============================================================
	always_comb begin
		mag = atten_r[SAMPLE_W-1] ? unsigned'(-atten_r) : unsigned'(atten_r);

		if (mag < KNEE_U)
			curve = SAMPLE_W'(mag * COMP_GAIN);
		else
			curve = SAMPLE_W'((mag - KNEE_U) / COMP_RATIO + OFFSET_U);

		// Put the sign back
		if (atten_r[SAMPLE_W-1])
			comp_next = sample_t'(-signed'(curve));
		else
			comp_next = sample_t'(curve);
	end

	// Stage two register
	always_ff @(posedge clk_sys) begin
		if (!reset_n)
			fm_comp_o <= '0;
		else
			fm_comp_o <= comp_next;
	end

endmodule

// File: project.f
logic/audio_pkg.sv
logic/digimax_regs.sv
logic/fm_compressor.sv
logic/audio_mixer.sv
logic/audio_top.sv
sim/audio_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the audio testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module audio_tb \
	-Mdir obj_dir \
	-o audio_sim \
	-f project.f

./obj_dir/audio_sim > sim.log
cat sim.log

if grep -q "^Regression passed$" sim.log; then
	echo "run_sim: simulation ok"
else
	echo "run_sim: simulation reported errors, see sim.log"
	exit 1
fi

// File: sim/audio_input.txt
# Columns for W lines: name W window(E or F) address data(hex)
# Columns for S lines: name S fm sid_l sid_r tape port exp_l exp_r
silence           S 0 0 0 0 0 0 0
sid_pos           S 0 1000 0 0 0 250 0
sid_neg           S 0 0 -1001 0 0 0 -251
tape_only         S 0 0 0 1 0 1024 1024
tape_sid          S 0 400 -400 1 0 1124 924
fm_low_pos        S 800 0 0 0 0 1400 1400
fm_low_neg        S -800 0 0 0 0 -1400 -1400
fm_tiny_neg       S -7 0 0 0 0 -12 -12
fm_below_knee     S 16049 0 0 0 0 28086 28086
fm_at_knee        S 16050 0 0 0 0 28088 28088
fm_high_pos       S 20000 0 0 0 0 28952 28952
fm_high_neg       S -20000 0 0 0 0 -28952 -28952
fm_max            S 32767 0 0 0 0 31745 31745
fm_min            S -32768 0 0 0 0 -31745 -31745
sat_pos           S 32767 131071 8000 0 0 32767 32767
sat_neg           S -32768 -131072 -8000 0 0 -32768 -32768
io1_select        S 0 0 0 0 1 0 0
wr_ch0            W E 0 10
mono              S 0 0 0 0 1 2048 2048
wr_addr_bit2      W E 4 7f
addr_bit2_ignored S 0 0 0 0 1 2048 2048
wr_wrong_win      W F 1 33
wrong_win_ignored S 0 0 0 0 1 2048 2048
wr_ch1            W E 1 20
ch0_ch1           S 0 0 0 0 1 2048 1024
wr_ch2            W E 2 08
ch2_added         S 0 0 0 0 1 2560 1024
wr_ch3            W E 3 04
quad              S 0 0 0 0 1 2560 1280
dac_sid_mix       S 0 400 -400 1 1 3684 2204
port_off          S 0 0 0 0 0 0 0
io2_select        S 0 0 0 0 2 0 0
wr2_ch1           W F 1 40
stereo            S 0 0 0 0 2 8192 0
wr2_ch0           W F 0 10
io2_quad          S 0 0 0 0 2 4096 1024
wr2_ch3           W F 3 02
port3_quad        S 0 0 0 0 3 4096 1152
wr3_ch1_full      W F 1 ff
wr3_ch2_full      W F 2 ff
dac_sat           S 800 0 0 0 3 32767 2552
final_off         S 0 0 0 0 0 0 0

// File: sim/audio_tb.sv
`timescale 1ns/100ps

module audio_tb;

	import audio_pkg::*;

	localparam string INPUT_FILE  = "sim/audio_input.txt";
	localparam int    LINE_W      = 8*160;
	localparam int    NAME_W      = 8*32;
	localparam int    HOLD_CYCLES = 8;

	logic                clk_sys;
	logic                reset_n;
	logic                io_e;
	logic                io_f;
	logic                cpu_we;
	logic [2:0]          cpu_addr;
	dac_byte_t           cpu_data;
	digimax_port_t       digimax_port;
	sample_t             fm_sample;
	sid_sample_t         sid_left;
	sid_sample_t         sid_right;
	logic                tape_sound;
	sample_t             audio_l;
	sample_t             audio_r;

	logic [LINE_W-1:0]   vec_q[$];
	int                  errors;
	int                  other_errors;
	int                  cycle_cnt;
	int                  cycle_limit;

	audio_top i_audio_top (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.io_e_i         (io_e),
		.io_f_i         (io_f),
		.cpu_we_i       (cpu_we),
		.cpu_addr_i     (cpu_addr),
		.cpu_data_i     (cpu_data),
		.digimax_port_i (digimax_port),
		.fm_sample_i    (fm_sample),
		.sid_left_i     (sid_left),
		.sid_right_i    (sid_right),
		.tape_sound_i   (tape_sound),
		.audio_l_o      (audio_l),
		.audio_r_o      (audio_r)
	);

	// 100 ns clock period
	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// Watchdog on the whole run
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	// ============================================================
	// Helpers
	// ============================================================
	task automatic check_value(input string test_name, input string what,
		input int expected, input int actual);
		if (expected !== actual) begin
			$display("Mismatch in %0s (%0s): expected %0d, actual %0d",
				test_name, what, expected, actual);
			errors++;
		end
	endtask

	// Keep only lines whose second field is a known operation
	task automatic load_vectors();
		int                fd;
		logic [LINE_W-1:0] line_buf;
		logic [NAME_W-1:0] name;
		logic [7:0]        op;

		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			$display("Error: could not open the vector file %0s", INPUT_FILE);
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line_buf = '0;
			if ($fgets(line_buf, fd) != 0) begin
				op = 8'h00;
				if ($sscanf(line_buf, "%s %c", name, op) == 2 && (op == "W" || op == "S"))
					vec_q.push_back(line_buf);
			end
		end
		$fclose(fd);
	endtask

	// One CPU write, window and write enable high for two cycles
	task automatic write_pulse(input logic [7:0] win, input int addr, input int data);
		@(posedge clk_sys);
		io_e     <= (win == "E");
		io_f     <= (win == "F");
		cpu_we   <= 1'b1;
		cpu_addr <= addr[2:0];
		cpu_data <= data[7:0];
		repeat (2) @(posedge clk_sys);
		io_e     <= 1'b0;
		io_f     <= 1'b0;
		cpu_we   <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic run_vector(input logic [LINE_W-1:0] line_buf);
		logic [NAME_W-1:0] name;
		logic [7:0]        op;
		logic [7:0]        win;
		string             test_name;
		int                n;
		int                addr;
		int                data;
		int                fm;
		int                sid_l;
		int                sid_r;
		int                tape;
		int                port;
		int                exp_l;
		int                exp_r;

		n = $sscanf(line_buf, "%s %c", name, op);
		test_name = $sformatf("%0s", name);
		if (op == "W") begin
			n = $sscanf(line_buf, "%s %c %c %d %h", name, op, win, addr, data);
			if (n != 5 || (win != "E" && win != "F")) begin
				$display("Error: write line %0s is malformed", test_name);
				other_errors++;
			end else begin
				write_pulse(win, addr, data);
			end
		end else begin
			n = $sscanf(line_buf, "%s %c %d %d %d %d %d %d %d",
				name, op, fm, sid_l, sid_r, tape, port, exp_l, exp_r);
			if (n != 9) begin
				$display("Error: steady line %0s is malformed", test_name);
				other_errors++;
			end else begin
				@(posedge clk_sys);
				fm_sample    <= sample_t'(fm);
				sid_left     <= sid_sample_t'(sid_l);
				sid_right    <= sid_sample_t'(sid_r);
				tape_sound   <= tape[0];
				digimax_port <= digimax_port_t'(port[1:0]);
				repeat (HOLD_CYCLES) @(posedge clk_sys);
				// Outputs are settled, sample away from the edge
				@(negedge clk_sys);
				check_value(test_name, "left", exp_l, int'(audio_l));
				check_value(test_name, "right", exp_r, int'(audio_r));
			end
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		reset_n      = 1'b0;
		io_e         = 1'b0;
		io_f         = 1'b0;
		cpu_we       = 1'b0;
		cpu_addr     = '0;
		cpu_data     = '0;
		digimax_port = DIGIMAX_OFF;
		fm_sample    = '0;
		sid_left     = '0;
		sid_right    = '0;
		tape_sound   = 1'b0;
		errors       = 0;
		other_errors = 0;
		cycle_cnt    = 0;
		cycle_limit  = 100;

		load_vectors();
		cycle_limit = 10 * vec_q.size() + 100;

		// Reset spans two rising edges
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("reset", "left", 0, int'(audio_l));
		check_value("reset", "right", 0, int'(audio_r));
		@(posedge clk_sys);
		reset_n <= 1'b1;

		foreach (vec_q[i])
			run_vector(vec_q[i]);

		$display("Run complete: %0d vectors, %0d mismatches, %0d other errors",
			vec_q.size(), errors, other_errors);
		if (errors == 0 && other_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
